// ==== sources.f ====
+incdir+source
source/irq_pkg.sv
source/irq_regs.sv
source/irq_gateway.sv
source/irq_prio_max_tree.sv
source/irq_target.sv
source/irq_ctrl_top.sv
sim/irq_tb.sv

// ==== Bender.yml ====
package:
  name: irq_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/irq_pkg.sv
      - source/irq_regs.sv
      - source/irq_gateway.sv
      - source/irq_prio_max_tree.sv
      - source/irq_target.sv
      - source/irq_ctrl_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/irq_tb.sv

// ==== sim/irq_tb.sv ====
// Interrupt controller testbench
`include "irq_cfg.svh"

module irq_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import irq_pkg::*;

  localparam int N  = `NUM_SRC;
  localparam int PW = `PRIO_W;

  // Cycle budgets per test, each including its reset
  localparam int BUDGET_PRIO    = 8 * 100;
  localparam int BUDGET_THRESH  = 220;
  localparam int BUDGET_ENABLE  = 150;
  localparam int BUDGET_LEVEL   = 150;
  localparam int BUDGET_EDGE    = 150;
  localparam int MIX_CYCLES     = 4000;
  localparam int BUDGET_MIX     = MIX_CYCLES + 100;
  localparam int TIMEOUT_CYCLES = BUDGET_PRIO + BUDGET_THRESH + BUDGET_ENABLE +
                                  BUDGET_LEVEL + BUDGET_EDGE + BUDGET_MIX + 500;

  logic             clk = 1'b0;
  logic             rst;
  logic             cmd_valid;
  irq_op_e          cmd_op;
  logic [SRC_W-1:0] cmd_addr;
  logic [PW-1:0]    cmd_data;
  logic [N-1:0]     src;
  logic             irq;
  logic             claim_valid;
  logic [SRC_W-1:0] claim_id;

  // Mirror of the controller state kept by the reference model
  logic [N-1:0][PW-1:0] m_prio;
  logic [N-1:0]         m_en;
  logic [N-1:0]         m_edge;
  logic [N-1:0]         m_pend;
  logic [N-1:0]         m_insvc;
  logic [N-1:0]         m_src_q;
  logic [PW-1:0]        m_thresh;
  logic                 m_irq;
  logic                 m_claim;
  logic [SRC_W-1:0]     m_claim_id;

  logic [31:0] lfsr = 32'h6132;
  int          cycle_cnt = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_errors = 0;
  int          tests = 0;

  irq_ctrl_top DUT (
    .clk_i         (clk),
    .rst_i         (rst),
    .cmd_valid_i   (cmd_valid),
    .cmd_op_i      (cmd_op),
    .cmd_addr_i    (cmd_addr),
    .cmd_data_i    (cmd_data),
    .src_i         (src),
    .irq_o         (irq),
    .claim_valid_o (claim_valid),
    .claim_id_o    (claim_id)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
  end

  // Hard stop once every test has had its full budget
  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Something failed");
    $finish;
  end

  //////////////////////////////
  // Random numbers
  //////////////////////////////

  // Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once for every bit taken
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // A plain scan for the best ready source where only a strictly greater priority
  // replaces the current pick
  function automatic void pick_best(input logic [N-1:0] ready, output logic found,
                                    output logic [SRC_W-1:0] idx, output logic [PW-1:0] prio);
    found = 1'b0;
    idx   = '0;
    prio  = '0;
    for (int i = 0; i < N; i++) begin
      if (ready[i] && (!found || m_prio[i] > prio)) begin
        found = 1'b1;
        idx   = SRC_W'(i);
        prio  = m_prio[i];
      end
    end
  endfunction

  task automatic model_reset();
    m_prio   = '0;
    m_en     = '0;
    m_edge   = '0;
    m_pend   = '0;
    m_insvc  = '0;
    m_src_q  = '0;
    m_thresh = '0;
    m_irq    = 1'b0;
    m_claim  = 1'b0;
  endtask

  // One rising edge: all next values come from the state before the edge
  task automatic model_step();
    logic [N-1:0]     claim_hit;
    logic [N-1:0]     complete_hit;
    logic [N-1:0]     ready;
    logic [N-1:0]     capture;
    logic             found;
    logic             above;
    logic [SRC_W-1:0] idx;
    logic [PW-1:0]    best;
    claim_hit    = '0;
    complete_hit = '0;
    if (m_claim) claim_hit[m_claim_id] = 1'b1;
    if (cmd_valid && cmd_op == OP_COMPLETE) complete_hit[cmd_addr] = 1'b1;
    // A source being claimed in this cycle is already out of the running
    ready = m_pend & m_en & ~claim_hit;
    pick_best(ready, found, idx, best);
    above = found && (best > m_thresh);
    // Busy sources drop new requests
    // An idle source in edge mode only takes a pin that was low one sample before
    for (int i = 0; i < N; i++) begin
      capture[i] = 1'b0;
      if (src[i] && !m_pend[i] && !m_insvc[i]) begin
        capture[i] = m_edge[i] ? !m_src_q[i] : 1'b1;
      end
    end
    m_irq   = above;
    m_claim = cmd_valid && (cmd_op == OP_CLAIM) && above;
    if (m_claim) m_claim_id = idx;
    m_pend  = (m_pend | capture) & ~claim_hit;
    m_insvc = (m_insvc & ~complete_hit) | claim_hit;
    m_src_q = src;
    if (cmd_valid) begin
      case (cmd_op)
        OP_SET_PRIO:   m_prio[cmd_addr] = cmd_data;
        OP_SET_ENABLE: m_en[cmd_addr]   = cmd_data[0];
        OP_SET_EDGE:   m_edge[cmd_addr] = cmd_data[0];
        OP_SET_THRESH: m_thresh         = cmd_data;
        default: ;
      endcase
    end
  endtask

  //////////////////////////////
  // Checks and drivers
  //////////////////////////////

  // Outputs are registered, so mid-cycle at the falling edge they are stable
  task automatic check_outputs();
    checks++;
    irq_a: assert (irq === m_irq) else begin
      $display("FAIL irq_o expected %h got %h at cycle %0d", m_irq, irq, cycle_cnt);
      test_errors++;
    end
    claim_valid_a: assert (claim_valid === m_claim) else begin
      $display("FAIL claim_valid_o expected %h got %h at cycle %0d",
               m_claim, claim_valid, cycle_cnt);
      test_errors++;
    end
    // The index only means something alongside a valid claim
    if (m_claim) begin
      claim_id_a: assert (claim_id === m_claim_id) else begin
        $display("FAIL claim_id_o expected %h got %h at cycle %0d",
                 m_claim_id, claim_id, cycle_cnt);
        test_errors++;
      end
    end
  endtask

  task automatic tick();
    @(posedge clk);
    model_step();
    @(negedge clk);
    check_outputs();
  endtask

  task automatic idle(int n);
    repeat (n) tick();
  endtask

  task automatic send_cmd(input irq_op_e op, input logic [SRC_W-1:0] addr,
                          input logic [PW-1:0] data);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_addr  = addr;
    cmd_data  = data;
    tick();
    cmd_valid = 1'b0;
    cmd_op    = OP_NOP;
  endtask

  // Reset is held over 16 rising edges and released at a falling edge
  task automatic apply_reset();
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd_op    = OP_NOP;
    cmd_addr  = '0;
    cmd_data  = '0;
    src       = '0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    model_reset();
  endtask

  // Random priorities for every source plus the chosen enables and edge types
  task automatic configure(logic [N-1:0] en_mask, logic [N-1:0] edge_mask, bit nonzero);
    logic [PW-1:0] p;
    for (int i = 0; i < N; i++) begin
      p = PW'(take_bits(PW));
      if (nonzero && p == '0) p = PW'(1);
      send_cmd(OP_SET_PRIO, SRC_W'(i), p);
      if (en_mask[i]) send_cmd(OP_SET_ENABLE, SRC_W'(i), PW'(1));
      if (edge_mask[i]) send_cmd(OP_SET_EDGE, SRC_W'(i), PW'(1));
    end
  endtask

  // Back-to-back claims, one more than there are sources, to drain the winners
  task automatic claim_all();
    repeat (N + 1) send_cmd(OP_CLAIM, '0, '0);
    idle(2);
  endtask

  task automatic finish_test(string name);
    $display("%-22s %s with %0d errors", name, (test_errors == 0) ? "passed" : "failed",
             test_errors);
    errors += test_errors;
    test_errors = 0;
    tests++;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_priority();
    for (int r = 0; r < 8; r++) begin
      apply_reset();
      configure('1, '0, 1'b0);
      // The last round uses one priority everywhere, so every pick is a tie
      if (r == 7) begin
        for (int i = 0; i < N; i++) send_cmd(OP_SET_PRIO, SRC_W'(i), PW'(5));
      end
      src = N'(take_bits(N)) | (N'(1) << r);
      idle(2);
      claim_all();
    end
  endtask

  task automatic test_threshold();
    apply_reset();
    configure('1, '0, 1'b0);
    src = N'(take_bits(N));
    idle(2);
    repeat (24) begin
      send_cmd(OP_SET_THRESH, '0, PW'(take_bits(PW)));
      idle(2);
      send_cmd(OP_CLAIM, '0, '0);
      idle(1);
    end
  endtask

  task automatic test_enable();
    logic [N-1:0] en;
    apply_reset();
    en = N'(take_bits(N));
    configure(en, '0, 1'b1);
    src = '1;
    idle(2);
    claim_all();
    // Disabled sources kept their pending bit and now become eligible
    for (int i = 0; i < N; i++) begin
      if (!en[i]) send_cmd(OP_SET_ENABLE, SRC_W'(i), PW'(1));
    end
    idle(2);
    claim_all();
  endtask

  task automatic test_level();
    logic [SRC_W-1:0] k;
    apply_reset();
    configure('1, '0, 1'b1);
    repeat (4) begin
      k      = SRC_W'(take_bits(SRC_W));
      src    = '0;
      src[k] = 1'b1;
      idle(2);
      send_cmd(OP_CLAIM, '0, '0);
      // In service, so the high pin must not bring it back
      idle(3);
      send_cmd(OP_COMPLETE, k, '0);
      // The pin is still high and the source pends again
      idle(2);
      send_cmd(OP_CLAIM, '0, '0);
      src = '0;
      idle(1);
      send_cmd(OP_COMPLETE, k, '0);
      idle(2);
    end
  endtask

  task automatic test_edge();
    logic [SRC_W-1:0] k;
    apply_reset();
    configure('1, '1, 1'b1);
    repeat (4) begin
      k      = SRC_W'(take_bits(SRC_W));
      src[k] = 1'b1;
      idle(2);
      // A fresh edge while pending is dropped
      src[k] = 1'b0;
      idle(1);
      src[k] = 1'b1;
      idle(1);
      send_cmd(OP_CLAIM, '0, '0);
      idle(1);
      // Same again while in service
      src[k] = 1'b0;
      idle(1);
      src[k] = 1'b1;
      idle(1);
      send_cmd(OP_COMPLETE, k, '0);
      // Held high after completion, no new request
      idle(3);
      src[k] = 1'b0;
      idle(2);
    end
  endtask

  task automatic test_mix();
    logic [SRC_W-1:0] k;
    logic [2:0]       op;
    apply_reset();
    configure('1, N'(take_bits(N)), 1'b0);
    repeat (MIX_CYCLES) begin
      // Roughly one pin in eight cycles flips
      if (take_bits(3) == 0) begin
        k      = SRC_W'(take_bits(SRC_W));
        src[k] = ~src[k];
      end
      op        = 3'(take_bits(3));
      cmd_valid = 1'(take_bits(1));
      cmd_op    = (op == 3'd7) ? OP_NOP : irq_op_e'(op);
      cmd_addr  = SRC_W'(take_bits(SRC_W));
      cmd_data  = PW'(take_bits(PW));
      tick();
    end
    cmd_valid = 1'b0;
    cmd_op    = OP_NOP;
    idle(2);
  endtask

  initial begin
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd_op    = OP_NOP;
    cmd_addr  = '0;
    cmd_data  = '0;
    src       = '0;
    test_priority();
    finish_test("priority selection");
    test_threshold();
    finish_test("threshold");
    test_enable();
    finish_test("enable masking");
    test_level();
    finish_test("level claim/complete");
    test_edge();
    finish_test("edge sources");
    test_mix();
    finish_test("random mix");
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : irq_tb

// ==== source/irq_ctrl_top.sv ====
// Interrupt controller top level
`include "irq_cfg.svh"

module irq_ctrl_top (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      cmd_valid_i,
  input  irq_pkg::irq_op_e          cmd_op_i,
  input  logic [irq_pkg::SRC_W-1:0] cmd_addr_i,
  input  logic [`PRIO_W-1:0]        cmd_data_i,
  input  logic [`NUM_SRC-1:0]       src_i,
  output logic                      irq_o,
  output logic                      claim_valid_o,
  output logic [irq_pkg::SRC_W-1:0] claim_id_o
);

  import irq_pkg::*;

  // Configuration held by the command decoder
  logic [`NUM_SRC-1:0][`PRIO_W-1:0] prio;
  logic [`NUM_SRC-1:0]              enable;
  logic [`NUM_SRC-1:0]              edge_type;
  logic [`PRIO_W-1:0]               thresh;

  // Strobes decoded from the command port
  logic                             claim_req;
  logic                             complete;
  logic [SRC_W-1:0]                 complete_id;

  // Pending and enabled sources offered to the tree
  logic [`NUM_SRC-1:0]              ready;

  // Winner of the tree
  logic [`PRIO_W-1:0]               max_prio;
  logic [SRC_W-1:0]                 max_idx;
  logic                             max_valid;

  //////////////////////////////
  // Command decoder
  //////////////////////////////

  irq_regs u_regs (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_op_i      (cmd_op_i),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_data_i    (cmd_data_i),
    .prio_o        (prio),
    .enable_o      (enable),
    .edge_o        (edge_type),
    .thresh_o      (thresh),
    .claim_req_o   (claim_req),
    .complete_o    (complete),
    .complete_id_o (complete_id)
  );

  //////////////////////////////
  // Gateway
  //////////////////////////////

  // The registered claim pulse that leaves the top also moves the source into service
  irq_gateway u_gateway (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .src_i         (src_i),
    .edge_i        (edge_type),
    .enable_i      (enable),
    .claim_i       (claim_valid_o),
    .claim_id_i    (claim_id_o),
    .complete_i    (complete),
    .complete_id_i (complete_id),
    .pending_o     (),
    .ready_o       (ready)
  );

  //////////////////////////////
  // Selection
  //////////////////////////////

  irq_prio_max_tree #(
    .NUM_SRC (`NUM_SRC),
    .WIDTH   (`PRIO_W)
  ) u_tree (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .values_i    (prio),
    .valid_i     (ready),
    .max_value_o (max_prio),
    .max_idx_o   (max_idx),
    .max_valid_o (max_valid)
  );

  //////////////////////////////
  // Target
  //////////////////////////////

  irq_target u_target (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .max_prio_i  (max_prio),
    .max_idx_i   (max_idx),
    .max_valid_i (max_valid),
    .thresh_i    (thresh),
    .claim_req_i (claim_req),
    .irq_o       (irq_o),
    .claim_o     (claim_valid_o),
    .claim_id_o  (claim_id_o)
  );

endmodule : irq_ctrl_top

// ==== source/irq_target.sv ====
// Interrupt target
`include "irq_cfg.svh"

module irq_target (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [`PRIO_W-1:0]        max_prio_i,
  input  logic [irq_pkg::SRC_W-1:0] max_idx_i,
  input  logic                      max_valid_i,
  input  logic [`PRIO_W-1:0]        thresh_i,
  input  logic                      claim_req_i,
  output logic                      irq_o,
  output logic                      claim_o,
  output logic [irq_pkg::SRC_W-1:0] claim_id_o
);

  // The tree has a winner and its priority is strictly above the threshold
  logic above;

  //////////////////////////////
  // Threshold comparison
  //////////////////////////////

  // Equal to the threshold is not enough, so a threshold of 0 still masks priority 0
  assign above = max_valid_i && (max_prio_i > thresh_i);

  //////////////////////////////
  // Interrupt line and claim
  //////////////////////////////

  // The interrupt line follows the comparison one cycle late
  // A claim registers the current winner and pulses only when that winner is above
  // the threshold, so a claim with nothing to take leaves every source alone
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      irq_o      <= 1'b0;
      claim_o    <= 1'b0;
      claim_id_o <= '0;
    end else begin
      irq_o   <= above;
      claim_o <= claim_req_i && above;
      if (claim_req_i) begin
        claim_id_o <= max_idx_i;
      end
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Every claim pulse answers a request of its own
  claim_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (claim_o && $past(claim_o)) |-> ($past(claim_req_i) && $past(claim_req_i, 2)))
    else $error("irq_target: claim pulse repeated without a second request");

endmodule : irq_target

// ==== source/irq_prio_max_tree.sv ====
// Priority maximum tree
module irq_prio_max_tree #(
  parameter  int NUM_SRC = 16,
  parameter  int WIDTH   = 3,
  localparam int IDX_W   = $clog2(NUM_SRC)
) (
  // Clock and reset only serve the assertions, the tree itself is combinational
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic [NUM_SRC-1:0][WIDTH-1:0] values_i,
  input  logic [NUM_SRC-1:0]            valid_i,
  output logic [WIDTH-1:0]              max_value_o,
  output logic [IDX_W-1:0]              max_idx_o,
  output logic                          max_valid_o
);

  // The leaf count is rounded up to a power of two
  // Node 0 is the root, the leaves occupy the last level
  localparam int NUM_LEVELS = $clog2(NUM_SRC);
  localparam int NUM_NODES  = 2**(NUM_LEVELS+1) - 1;

  logic [NUM_NODES-1:0]            vld_tree;
  logic [NUM_NODES-1:0][IDX_W-1:0] idx_tree;
  logic [NUM_NODES-1:0][WIDTH-1:0] val_tree;

  // The tree needs at least one comparison level
  if (NUM_SRC < 2) begin : gen_count_check
    $error("irq_prio_max_tree: NUM_SRC must be at least 2");
  end

  //////////////////////////////
  // Tree construction
  //////////////////////////////

  for (genvar level = 0; level <= NUM_LEVELS; level++) begin : gen_level
    // First node index on this level and on the level of its children
    localparam int BASE_PA = 2**level - 1;
    localparam int BASE_CH = 2**(level+1) - 1;

    for (genvar offset = 0; offset < 2**level; offset++) begin : gen_node
      localparam int PA = BASE_PA + offset;

      if (level == NUM_LEVELS) begin : gen_leaf
        if (offset < NUM_SRC) begin : gen_src
          assign vld_tree[PA] = valid_i[offset];
          assign idx_tree[PA] = IDX_W'(offset);
          assign val_tree[PA] = values_i[offset];
        end else begin : gen_pad
          // Padding leaves are never valid
          assign vld_tree[PA] = 1'b0;
          assign idx_tree[PA] = '0;
          assign val_tree[PA] = '0;
        end
      end else begin : gen_inner
        localparam int C0 = BASE_CH + 2*offset;
        localparam int C1 = C0 + 1;

        logic pick_c1;

        // Take the upper child only when it is valid and the lower one is not,
        // or when both are valid and the upper one is strictly greater
        // Ties stay with C0, which always holds the lower source indices
        assign pick_c1 = vld_tree[C1] & (~vld_tree[C0] | (val_tree[C1] > val_tree[C0]));

        assign vld_tree[PA] = pick_c1 ? vld_tree[C1] : vld_tree[C0];
        assign idx_tree[PA] = pick_c1 ? idx_tree[C1] : idx_tree[C0];
        assign val_tree[PA] = pick_c1 ? val_tree[C1] : val_tree[C0];
      end
    end : gen_node
  end : gen_level

  // The winner sits at the root
  assign max_valid_o = vld_tree[0];
  assign max_idx_o   = idx_tree[0];
  assign max_value_o = val_tree[0];

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Any valid leaf must make it all the way to the root
  valid_or_a: assert property (@(posedge clk_i) disable iff (rst_i)
    max_valid_o == (|valid_i))
    else $error("irq_prio_max_tree: root valid does not match input valids");

  // With nothing valid the tree falls back to source 0
  idle_idx_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !max_valid_o |-> (max_idx_o == '0))
    else $error("irq_prio_max_tree: index %0d with no valid input", max_idx_o);

endmodule : irq_prio_max_tree

// ==== source/irq_gateway.sv ====
// Interrupt source gateway
`include "irq_cfg.svh"

module irq_gateway (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [`NUM_SRC-1:0]       src_i,
  input  logic [`NUM_SRC-1:0]       edge_i,
  input  logic [`NUM_SRC-1:0]       enable_i,
  input  logic                      claim_i,
  input  logic [irq_pkg::SRC_W-1:0] claim_id_i,
  input  logic                      complete_i,
  input  logic [irq_pkg::SRC_W-1:0] complete_id_i,
  output logic [`NUM_SRC-1:0]       pending_o,
  output logic [`NUM_SRC-1:0]       ready_o
);

  import irq_pkg::*;

  // Previous pin sample, used to spot rising edges
  logic [`NUM_SRC-1:0] src_q;
  // Waiting to be claimed
  logic [`NUM_SRC-1:0] pending_q;
  // Claimed by the target and not yet completed
  logic [`NUM_SRC-1:0] in_service_q;

  // One-hot decodes of the claim and complete source indices
  logic [`NUM_SRC-1:0] claim_hit;
  logic [`NUM_SRC-1:0] complete_hit;
  // Sources that become pending at this edge
  logic [`NUM_SRC-1:0] capture;

  always_comb begin
    for (int i = 0; i < `NUM_SRC; i++) begin
      claim_hit[i]    = claim_i && (claim_id_i == SRC_W'(i));
      complete_hit[i] = complete_i && (complete_id_i == SRC_W'(i));
    end
  end

  //////////////////////////////
  // Capture rules
  //////////////////////////////

  // Level mode takes a high pin, edge mode needs the previous sample low as well
  // Anything arriving while the source is pending or in service is dropped
  assign capture = src_i & (~edge_i | ~src_q) & ~pending_q & ~in_service_q;

  // A claim moves the source from pending into service in one step
  // If a complete for the same source lands on the claim edge, the claim wins,
  // as that complete cannot refer to a claim that has not finished yet
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      src_q        <= '0;
      pending_q    <= '0;
      in_service_q <= '0;
    end else begin
      src_q        <= src_i;
      pending_q    <= (pending_q | capture) & ~claim_hit;
      in_service_q <= (in_service_q & ~complete_hit) | claim_hit;
    end
  end

  assign pending_o = pending_q;

  // The source being claimed right now is hidden from the tree for this cycle,
  // so a back-to-back claim picks the next winner instead of the same one
  assign ready_o = pending_q & enable_i & ~claim_hit;

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Pending and in service exclude each other for every source
  pend_serv_excl_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (pending_q & in_service_q) == '0)
    else $error("irq_gateway: source both pending and in service");

  // The target only claims what the tree could have picked one cycle earlier
  claim_ready_a: assert property (@(posedge clk_i) disable iff (rst_i)
    claim_i |-> (pending_q[claim_id_i] && enable_i[claim_id_i]))
    else $error("irq_gateway: claim of source %0d that is not ready", claim_id_i);

endmodule : irq_gateway

// ==== source/irq_regs.sv ====
// Command decoder and configuration
`include "irq_cfg.svh"

module irq_regs (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  cmd_valid_i,
  input  irq_pkg::irq_op_e                      cmd_op_i,
  input  logic [irq_pkg::SRC_W-1:0]             cmd_addr_i,
  input  logic [`PRIO_W-1:0]                    cmd_data_i,
  output logic [`NUM_SRC-1:0][`PRIO_W-1:0]      prio_o,
  output logic [`NUM_SRC-1:0]                   enable_o,
  output logic [`NUM_SRC-1:0]                   edge_o,
  output logic [`PRIO_W-1:0]                    thresh_o,
  output logic                                  claim_req_o,
  output logic                                  complete_o,
  output logic [irq_pkg::SRC_W-1:0]             complete_id_o
);

  import irq_pkg::*;

  // Configuration registers, one field per source plus the single threshold
  logic [`NUM_SRC-1:0][`PRIO_W-1:0] prio_q;
  logic [`NUM_SRC-1:0]              enable_q;
  logic [`NUM_SRC-1:0]              edge_q;
  logic [`PRIO_W-1:0]               thresh_q;

  // High when a valid command carries a source index in its address field
  logic addr_cmd;

  //////////////////////////////
  // Configuration writes
  //////////////////////////////

  // A write lands at the command edge and is visible the following cycle
  // Claim, complete and NOP leave the configuration alone
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q   <= '0;
      enable_q <= '0;
      edge_q   <= '0;
      thresh_q <= '0;
    end else if (cmd_valid_i) begin
      case (cmd_op_i)
        OP_SET_PRIO:   prio_q[cmd_addr_i]   <= cmd_data_i;
        OP_SET_ENABLE: enable_q[cmd_addr_i] <= cmd_data_i[0];
        // Data bit 0 set selects rising-edge capture, clear selects level
        OP_SET_EDGE:   edge_q[cmd_addr_i]   <= cmd_data_i[0];
        OP_SET_THRESH: thresh_q             <= cmd_data_i;
        default: ;
      endcase
    end
  end

  assign prio_o   = prio_q;
  assign enable_o = enable_q;
  assign edge_o   = edge_q;
  assign thresh_o = thresh_q;

  //////////////////////////////
  // Claim and complete strobes
  //////////////////////////////

  // These are pure decodes of the command inputs, so they act at the command edge
  assign claim_req_o   = cmd_valid_i && (cmd_op_i == OP_CLAIM);
  assign complete_o    = cmd_valid_i && (cmd_op_i == OP_COMPLETE);
  assign complete_id_o = cmd_addr_i;

  assign addr_cmd = cmd_valid_i && (cmd_op_i inside {OP_SET_PRIO, OP_SET_ENABLE,
                                                     OP_SET_EDGE, OP_COMPLETE});

  // A per-source command must name a source that exists
  addr_in_range_a: assert property (@(posedge clk_i) disable iff (rst_i)
    addr_cmd |-> (cmd_addr_i < `NUM_SRC))
    else $error("irq_regs: source address %0d out of range", cmd_addr_i);

endmodule : irq_regs

// ==== source/irq_pkg.sv ====
// Interrupt controller package
`include "irq_cfg.svh"

package irq_pkg;

  //////////////////////////////
  // Derived widths
  //////////////////////////////

  // Width of a source index on the command port and the claim response
  localparam int SRC_W = $clog2(`NUM_SRC);

  // Width of the opcode field on the command port
  localparam int OP_W = 3;

  //////////////////////////////
  // Command opcodes
  //////////////////////////////

  // Per-source opcodes take the source from the address field
  // Threshold and claim ignore the address
  typedef enum logic [OP_W-1:0] {
    OP_NOP        = 3'd0,
    OP_SET_PRIO   = 3'd1,
    OP_SET_ENABLE = 3'd2,
    OP_SET_EDGE   = 3'd3,
    OP_SET_THRESH = 3'd4,
    OP_CLAIM      = 3'd5,
    OP_COMPLETE   = 3'd6
  } irq_op_e;

endpackage : irq_pkg

// ==== source/irq_cfg.svh ====
// Interrupt controller sizes
`ifndef IRQ_CFG_SVH
`define IRQ_CFG_SVH

// Number of interrupt source pins seen by the controller
`define NUM_SRC 16

// Width of a source priority and of the target threshold
// A priority of 0 can never exceed the threshold, so it acts as "never interrupt"
`define PRIO_W 3

`endif
